//--- hw/axi_lite_mem_pkg.sv
package axi_lite_mem_pkg;

  // Bus geometry
  localparam int unsigned AddrWidth  = 12;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  localparam int unsigned ProtWidth  = 3;
  localparam int unsigned CacheWidth = 4;
  localparam int unsigned SizeWidth  = 3;

  // Memory geometry, 256 words cover bytes 0x000 to 0x3ff
  localparam int unsigned MemWords     = 256;
  localparam int unsigned MemIdxWidth  = $clog2(MemWords);
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);
  localparam int unsigned MemAddrWidth = MemIdxWidth + ByteOffWidth;

  // Upper half needs a privileged write
  localparam logic [AddrWidth-1:0] PrivBase = 12'h200;

  // AxCACHE bit positions
  localparam int unsigned CacheBufferableBit = 0;
  localparam int unsigned CacheModifiableBit = 1;

  // AxPROT bit positions
  localparam int unsigned ProtPrivBit  = 0;
  localparam int unsigned ProtInstrBit = 2;

  // Every transfer moves one full data word
  localparam logic [SizeWidth-1:0] AxiSize = SizeWidth'(ByteOffWidth);

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_WR_COMMIT = 3'd1,
    ST_WR_RESP   = 3'd2,
    ST_RD_WAIT   = 3'd3,
    ST_RD_RESP   = 3'd4
  } sub_state_e;

endpackage

//--- hw/sram_sp.sv
`timescale 1ns/1ps

module sram_sp (
  input  logic                                     clk_i,
  input  logic                                     req_i,
  input  logic                                     we_i,
  input  logic [axi_lite_mem_pkg::StrbWidth-1:0]   be_i,
  input  logic [axi_lite_mem_pkg::MemIdxWidth-1:0] idx_i,
  input  logic [axi_lite_mem_pkg::DataWidth-1:0]   wdata_i,
  output logic [axi_lite_mem_pkg::DataWidth-1:0]   rdata_o
);
  import axi_lite_mem_pkg::*;

  logic [DataWidth-1:0] mem_q [MemWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only strobed byte lanes change
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (be_i[b]) begin
            mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

endmodule

//--- hw/axi_lite_to_axi.sv
`timescale 1ns/1ps

module axi_lite_to_axi (
  // Lite subordinate port
  input  logic [axi_lite_mem_pkg::AddrWidth-1:0]  sbr_aw_addr_i,
  input  logic [axi_lite_mem_pkg::ProtWidth-1:0]  sbr_aw_prot_i,
  input  logic                                    sbr_aw_valid_i,
  output logic                                    sbr_aw_ready_o,
  input  logic [axi_lite_mem_pkg::DataWidth-1:0]  sbr_w_data_i,
  input  logic [axi_lite_mem_pkg::StrbWidth-1:0]  sbr_w_strb_i,
  input  logic                                    sbr_w_valid_i,
  output logic                                    sbr_w_ready_o,
  output axi_lite_mem_pkg::resp_e                 sbr_b_resp_o,
  output logic                                    sbr_b_valid_o,
  input  logic                                    sbr_b_ready_i,
  input  logic [axi_lite_mem_pkg::AddrWidth-1:0]  sbr_ar_addr_i,
  input  logic [axi_lite_mem_pkg::ProtWidth-1:0]  sbr_ar_prot_i,
  input  logic                                    sbr_ar_valid_i,
  output logic                                    sbr_ar_ready_o,
  output logic [axi_lite_mem_pkg::DataWidth-1:0]  sbr_r_data_o,
  output axi_lite_mem_pkg::resp_e                 sbr_r_resp_o,
  output logic                                    sbr_r_valid_o,
  input  logic                                    sbr_r_ready_i,
  // Cache attributes, plain levels
  input  logic [axi_lite_mem_pkg::CacheWidth-1:0] sbr_aw_cache_i,
  input  logic [axi_lite_mem_pkg::CacheWidth-1:0] sbr_ar_cache_i,
  // AXI4 manager port
  output logic [axi_lite_mem_pkg::AddrWidth-1:0]  mgr_aw_addr_o,
  output logic [axi_lite_mem_pkg::ProtWidth-1:0]  mgr_aw_prot_o,
  output logic [axi_lite_mem_pkg::SizeWidth-1:0]  mgr_aw_size_o,
  output logic [axi_lite_mem_pkg::CacheWidth-1:0] mgr_aw_cache_o,
  output logic                                    mgr_aw_valid_o,
  input  logic                                    mgr_aw_ready_i,
  output logic [axi_lite_mem_pkg::DataWidth-1:0]  mgr_w_data_o,
  output logic [axi_lite_mem_pkg::StrbWidth-1:0]  mgr_w_strb_o,
  output logic                                    mgr_w_last_o,
  output logic                                    mgr_w_valid_o,
  input  logic                                    mgr_w_ready_i,
  input  axi_lite_mem_pkg::resp_e                 mgr_b_resp_i,
  input  logic                                    mgr_b_valid_i,
  output logic                                    mgr_b_ready_o,
  output logic [axi_lite_mem_pkg::AddrWidth-1:0]  mgr_ar_addr_o,
  output logic [axi_lite_mem_pkg::ProtWidth-1:0]  mgr_ar_prot_o,
  output logic [axi_lite_mem_pkg::SizeWidth-1:0]  mgr_ar_size_o,
  output logic [axi_lite_mem_pkg::CacheWidth-1:0] mgr_ar_cache_o,
  output logic                                    mgr_ar_valid_o,
  input  logic                                    mgr_ar_ready_i,
  input  logic [axi_lite_mem_pkg::DataWidth-1:0]  mgr_r_data_i,
  input  axi_lite_mem_pkg::resp_e                 mgr_r_resp_i,
  input  logic                                    mgr_r_valid_i,
  output logic                                    mgr_r_ready_o
);
  import axi_lite_mem_pkg::*;

  // Write address, promoted to a single full-width beat
  assign mgr_aw_addr_o  = sbr_aw_addr_i;
  assign mgr_aw_prot_o  = sbr_aw_prot_i;
  assign mgr_aw_size_o  = AxiSize;
  assign mgr_aw_cache_o = sbr_aw_cache_i;
  assign mgr_aw_valid_o = sbr_aw_valid_i;
  assign sbr_aw_ready_o = mgr_aw_ready_i;

  // Lite data is always the only and therefore last beat
  assign mgr_w_data_o  = sbr_w_data_i;
  assign mgr_w_strb_o  = sbr_w_strb_i;
  assign mgr_w_last_o  = 1'b1;
  assign mgr_w_valid_o = sbr_w_valid_i;
  assign sbr_w_ready_o = mgr_w_ready_i;

  assign sbr_b_resp_o  = mgr_b_resp_i;
  assign sbr_b_valid_o = mgr_b_valid_i;
  assign mgr_b_ready_o = sbr_b_ready_i;

  // Read address
  assign mgr_ar_addr_o  = sbr_ar_addr_i;
  assign mgr_ar_prot_o  = sbr_ar_prot_i;
  assign mgr_ar_size_o  = AxiSize;
  assign mgr_ar_cache_o = sbr_ar_cache_i;
  assign mgr_ar_valid_o = sbr_ar_valid_i;
  assign sbr_ar_ready_o = mgr_ar_ready_i;

  assign sbr_r_data_o  = mgr_r_data_i;
  assign sbr_r_resp_o  = mgr_r_resp_i;
  assign sbr_r_valid_o = mgr_r_valid_i;
  assign mgr_r_ready_o = sbr_r_ready_i;

endmodule

//--- hw/axi_mem_sub.sv
`timescale 1ns/1ps

module axi_mem_sub (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // AXI4 subordinate port
  input  logic [axi_lite_mem_pkg::AddrWidth-1:0]   mgr_aw_addr_i,
  input  logic [axi_lite_mem_pkg::ProtWidth-1:0]   mgr_aw_prot_i,
  input  logic [axi_lite_mem_pkg::SizeWidth-1:0]   mgr_aw_size_i,
  input  logic [axi_lite_mem_pkg::CacheWidth-1:0]  mgr_aw_cache_i,
  input  logic                                     mgr_aw_valid_i,
  output logic                                     mgr_aw_ready_o,
  input  logic [axi_lite_mem_pkg::DataWidth-1:0]   mgr_w_data_i,
  input  logic [axi_lite_mem_pkg::StrbWidth-1:0]   mgr_w_strb_i,
  input  logic                                     mgr_w_last_i,
  input  logic                                     mgr_w_valid_i,
  output logic                                     mgr_w_ready_o,
  output axi_lite_mem_pkg::resp_e                  mgr_b_resp_o,
  output logic                                     mgr_b_valid_o,
  input  logic                                     mgr_b_ready_i,
  input  logic [axi_lite_mem_pkg::AddrWidth-1:0]   mgr_ar_addr_i,
  input  logic [axi_lite_mem_pkg::ProtWidth-1:0]   mgr_ar_prot_i,
  input  logic [axi_lite_mem_pkg::SizeWidth-1:0]   mgr_ar_size_i,
  input  logic [axi_lite_mem_pkg::CacheWidth-1:0]  mgr_ar_cache_i,
  input  logic                                     mgr_ar_valid_i,
  output logic                                     mgr_ar_ready_o,
  output logic [axi_lite_mem_pkg::DataWidth-1:0]   mgr_r_data_o,
  output axi_lite_mem_pkg::resp_e                  mgr_r_resp_o,
  output logic                                     mgr_r_valid_o,
  input  logic                                     mgr_r_ready_i,
  // SRAM port
  output logic                                     mem_req_o,
  output logic                                     mem_we_o,
  output logic [axi_lite_mem_pkg::StrbWidth-1:0]   mem_be_o,
  output logic [axi_lite_mem_pkg::MemIdxWidth-1:0] mem_idx_o,
  output logic [axi_lite_mem_pkg::DataWidth-1:0]   mem_wdata_o,
  input  logic [axi_lite_mem_pkg::DataWidth-1:0]   mem_rdata_i
);
  import axi_lite_mem_pkg::*;

  sub_state_e state_q, state_d;
  resp_e      resp_q, wr_resp, rd_resp;
  logic       idle, wr_hs, rd_hs, wr_buffered;

  // Held write for the non-bufferable path, plus the read word
  logic [MemIdxWidth-1:0] pend_idx_q;
  logic [StrbWidth-1:0]   pend_be_q;
  logic [DataWidth-1:0]   pend_data_q;
  logic [DataWidth-1:0]   rdata_q;

  // Decode shared by both address channels
  function automatic resp_e check_access(
    input logic [AddrWidth-1:0]  addr,
    input logic [SizeWidth-1:0]  size,
    input logic [CacheWidth-1:0] cache,
    input logic                  beat_ok,
    input logic                  access_ok
  );
    resp_e resp;
    logic  cache_ok;
    // Allocate hints are illegal on a non-modifiable access
    cache_ok = cache[CacheModifiableBit] || (cache[3:2] == 2'b00);
    resp     = RESP_OKAY;
    if (addr[AddrWidth-1:MemAddrWidth] != '0) begin
      resp = RESP_DECERR;
    end else if (size != AxiSize || !beat_ok || !cache_ok || !access_ok) begin
      resp = RESP_SLVERR;
    end
    return resp;
  endfunction

  // Privileged half needs prot bit 0 on writes; reads are data only
  assign wr_resp = check_access(mgr_aw_addr_i, mgr_aw_size_i, mgr_aw_cache_i, mgr_w_last_i,
                                (mgr_aw_addr_i < PrivBase) || mgr_aw_prot_i[ProtPrivBit]);
  assign rd_resp = check_access(mgr_ar_addr_i, mgr_ar_size_i, mgr_ar_cache_i, 1'b1,
                                !mgr_ar_prot_i[ProtInstrBit]);

  assign wr_buffered = mgr_aw_cache_i[CacheBufferableBit];

  // AW and W are taken together, writes win over reads
  assign idle  = (state_q == ST_IDLE);
  assign wr_hs = idle && mgr_aw_valid_i && mgr_w_valid_i;
  assign rd_hs = idle && !(mgr_aw_valid_i && mgr_w_valid_i) && mgr_ar_valid_i;

  assign mgr_aw_ready_o = wr_hs;
  assign mgr_w_ready_o  = wr_hs;
  assign mgr_ar_ready_o = rd_hs;

  assign mgr_b_valid_o = (state_q == ST_WR_RESP);
  assign mgr_b_resp_o  = resp_q;
  assign mgr_r_valid_o = (state_q == ST_RD_RESP);
  assign mgr_r_resp_o  = resp_q;
  assign mgr_r_data_o  = rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (wr_hs) begin
          state_d = (wr_resp == RESP_OKAY && !wr_buffered) ? ST_WR_COMMIT : ST_WR_RESP;
        end else if (rd_hs) begin
          state_d = ST_RD_WAIT;
        end
      end
      ST_WR_COMMIT: state_d = ST_WR_RESP;
      ST_WR_RESP: begin
        if (mgr_b_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_RD_WAIT: state_d = ST_RD_RESP;
      ST_RD_RESP: begin
        if (mgr_r_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // SRAM access: commit stage first, then early write, then read
  always_comb begin
    mem_req_o   = 1'b0;
    mem_we_o    = 1'b0;
    mem_be_o    = '0;
    mem_idx_o   = '0;
    mem_wdata_o = '0;
    if (state_q == ST_WR_COMMIT) begin
      mem_req_o   = 1'b1;
      mem_we_o    = 1'b1;
      mem_be_o    = pend_be_q;
      mem_idx_o   = pend_idx_q;
      mem_wdata_o = pend_data_q;
    end else if (wr_hs && wr_resp == RESP_OKAY && wr_buffered) begin
      mem_req_o   = 1'b1;
      mem_we_o    = 1'b1;
      mem_be_o    = mgr_w_strb_i;
      mem_idx_o   = mgr_aw_addr_i[MemAddrWidth-1:ByteOffWidth];
      mem_wdata_o = mgr_w_data_i;
    end else if (rd_hs && rd_resp == RESP_OKAY) begin
      mem_req_o = 1'b1;
      mem_idx_o = mgr_ar_addr_i[MemAddrWidth-1:ByteOffWidth];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      resp_q      <= wr_resp;
      pend_idx_q  <= mgr_aw_addr_i[MemAddrWidth-1:ByteOffWidth];
      pend_be_q   <= mgr_w_strb_i;
      pend_data_q <= mgr_w_data_i;
    end else if (rd_hs) begin
      resp_q <= rd_resp;
    end
    // SRAM word arrives one cycle after the read request
    if (state_q == ST_RD_WAIT) begin
      rdata_q <= (resp_q == RESP_OKAY) ? mem_rdata_i : '0;
    end
  end

endmodule

//--- hw/axi_lite_mem_top.sv
`timescale 1ns/1ps

module axi_lite_mem_top (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // AXI4-Lite port
  input  logic [axi_lite_mem_pkg::AddrWidth-1:0]  aw_addr_i,
  input  logic [axi_lite_mem_pkg::ProtWidth-1:0]  aw_prot_i,
  input  logic                                    aw_valid_i,
  output logic                                    aw_ready_o,
  input  logic [axi_lite_mem_pkg::DataWidth-1:0]  w_data_i,
  input  logic [axi_lite_mem_pkg::StrbWidth-1:0]  w_strb_i,
  input  logic                                    w_valid_i,
  output logic                                    w_ready_o,
  output axi_lite_mem_pkg::resp_e                 b_resp_o,
  output logic                                    b_valid_o,
  input  logic                                    b_ready_i,
  input  logic [axi_lite_mem_pkg::AddrWidth-1:0]  ar_addr_i,
  input  logic [axi_lite_mem_pkg::ProtWidth-1:0]  ar_prot_i,
  input  logic                                    ar_valid_i,
  output logic                                    ar_ready_o,
  output logic [axi_lite_mem_pkg::DataWidth-1:0]  r_data_o,
  output axi_lite_mem_pkg::resp_e                 r_resp_o,
  output logic                                    r_valid_o,
  input  logic                                    r_ready_i,
  input  logic [axi_lite_mem_pkg::CacheWidth-1:0] aw_cache_i,
  input  logic [axi_lite_mem_pkg::CacheWidth-1:0] ar_cache_i
);
  import axi_lite_mem_pkg::*;

  // AXI4 link between adapter and subordinate
  logic [AddrWidth-1:0]  axi_aw_addr, axi_ar_addr;
  logic [ProtWidth-1:0]  axi_aw_prot, axi_ar_prot;
  logic [SizeWidth-1:0]  axi_aw_size, axi_ar_size;
  logic [CacheWidth-1:0] axi_aw_cache, axi_ar_cache;
  logic                  axi_aw_valid, axi_aw_ready, axi_ar_valid, axi_ar_ready;
  logic [DataWidth-1:0]  axi_w_data, axi_r_data;
  logic [StrbWidth-1:0]  axi_w_strb;
  logic                  axi_w_last, axi_w_valid, axi_w_ready;
  resp_e                 axi_b_resp, axi_r_resp;
  logic                  axi_b_valid, axi_b_ready, axi_r_valid, axi_r_ready;

  // SRAM port
  logic                   mem_req, mem_we;
  logic [StrbWidth-1:0]   mem_be;
  logic [MemIdxWidth-1:0] mem_idx;
  logic [DataWidth-1:0]   mem_wdata, mem_rdata;

  axi_lite_to_axi i_lite_to_axi (
    .sbr_aw_addr_i (aw_addr_i),    .sbr_aw_prot_i (aw_prot_i),
    .sbr_aw_valid_i(aw_valid_i),   .sbr_aw_ready_o(aw_ready_o),
    .sbr_w_data_i  (w_data_i),     .sbr_w_strb_i  (w_strb_i),
    .sbr_w_valid_i (w_valid_i),    .sbr_w_ready_o (w_ready_o),
    .sbr_b_resp_o  (b_resp_o),     .sbr_b_valid_o (b_valid_o),
    .sbr_b_ready_i (b_ready_i),
    .sbr_ar_addr_i (ar_addr_i),    .sbr_ar_prot_i (ar_prot_i),
    .sbr_ar_valid_i(ar_valid_i),   .sbr_ar_ready_o(ar_ready_o),
    .sbr_r_data_o  (r_data_o),     .sbr_r_resp_o  (r_resp_o),
    .sbr_r_valid_o (r_valid_o),    .sbr_r_ready_i (r_ready_i),
    .sbr_aw_cache_i(aw_cache_i),   .sbr_ar_cache_i(ar_cache_i),
    .mgr_aw_addr_o (axi_aw_addr),  .mgr_aw_prot_o (axi_aw_prot),
    .mgr_aw_size_o (axi_aw_size),  .mgr_aw_cache_o(axi_aw_cache),
    .mgr_aw_valid_o(axi_aw_valid), .mgr_aw_ready_i(axi_aw_ready),
    .mgr_w_data_o  (axi_w_data),   .mgr_w_strb_o  (axi_w_strb),
    .mgr_w_last_o  (axi_w_last),   .mgr_w_valid_o (axi_w_valid),
    .mgr_w_ready_i (axi_w_ready),
    .mgr_b_resp_i  (axi_b_resp),   .mgr_b_valid_i (axi_b_valid),
    .mgr_b_ready_o (axi_b_ready),
    .mgr_ar_addr_o (axi_ar_addr),  .mgr_ar_prot_o (axi_ar_prot),
    .mgr_ar_size_o (axi_ar_size),  .mgr_ar_cache_o(axi_ar_cache),
    .mgr_ar_valid_o(axi_ar_valid), .mgr_ar_ready_i(axi_ar_ready),
    .mgr_r_data_i  (axi_r_data),   .mgr_r_resp_i  (axi_r_resp),
    .mgr_r_valid_i (axi_r_valid),  .mgr_r_ready_o (axi_r_ready)
  );

  axi_mem_sub i_mem_sub (
    .clk_i         (clk_i),        .rst_n_i       (rst_n_i),
    .mgr_aw_addr_i (axi_aw_addr),  .mgr_aw_prot_i (axi_aw_prot),
    .mgr_aw_size_i (axi_aw_size),  .mgr_aw_cache_i(axi_aw_cache),
    .mgr_aw_valid_i(axi_aw_valid), .mgr_aw_ready_o(axi_aw_ready),
    .mgr_w_data_i  (axi_w_data),   .mgr_w_strb_i  (axi_w_strb),
    .mgr_w_last_i  (axi_w_last),   .mgr_w_valid_i (axi_w_valid),
    .mgr_w_ready_o (axi_w_ready),
    .mgr_b_resp_o  (axi_b_resp),   .mgr_b_valid_o (axi_b_valid),
    .mgr_b_ready_i (axi_b_ready),
    .mgr_ar_addr_i (axi_ar_addr),  .mgr_ar_prot_i (axi_ar_prot),
    .mgr_ar_size_i (axi_ar_size),  .mgr_ar_cache_i(axi_ar_cache),
    .mgr_ar_valid_i(axi_ar_valid), .mgr_ar_ready_o(axi_ar_ready),
    .mgr_r_data_o  (axi_r_data),   .mgr_r_resp_o  (axi_r_resp),
    .mgr_r_valid_o (axi_r_valid),  .mgr_r_ready_i (axi_r_ready),
    .mem_req_o     (mem_req),      .mem_we_o      (mem_we),
    .mem_be_o      (mem_be),       .mem_idx_o     (mem_idx),
    .mem_wdata_o   (mem_wdata),    .mem_rdata_i   (mem_rdata)
  );

  sram_sp i_sram (
    .clk_i  (clk_i),
    .req_i  (mem_req),
    .we_i   (mem_we),
    .be_i   (mem_be),
    .idx_i  (mem_idx),
    .wdata_i(mem_wdata),
    .rdata_o(mem_rdata)
  );

endmodule

//--- verification/axi_lite_mem_sva.sv
`timescale 1ns/1ps

module axi_lite_mem_sva (
  input logic                                   clk_i,
  input logic                                   rst_n_i,
  input logic [axi_lite_mem_pkg::AddrWidth-1:0] aw_addr_i,
  input logic [axi_lite_mem_pkg::ProtWidth-1:0] aw_prot_i,
  input logic                                   aw_valid_i,
  input logic                                   aw_ready_o,
  input logic [axi_lite_mem_pkg::DataWidth-1:0] w_data_i,
  input logic [axi_lite_mem_pkg::StrbWidth-1:0] w_strb_i,
  input logic                                   w_valid_i,
  input logic                                   w_ready_o,
  input axi_lite_mem_pkg::resp_e                b_resp_o,
  input logic                                   b_valid_o,
  input logic                                   b_ready_i,
  input logic [axi_lite_mem_pkg::AddrWidth-1:0] ar_addr_i,
  input logic                                   ar_valid_i,
  input logic                                   ar_ready_o,
  input logic [axi_lite_mem_pkg::DataWidth-1:0] r_data_o,
  input axi_lite_mem_pkg::resp_e                r_resp_o,
  input logic                                   r_valid_o,
  input logic                                   r_ready_i
);

  // No response pending right after reset
  assert property (@(posedge clk_i) !rst_n_i |=> !b_valid_o && !r_valid_o)
    else $error("Response valid high after reset");

  // Stalled channels keep valid and payload
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_valid_i && !aw_ready_o |=> aw_valid_i && $stable(aw_addr_i) && $stable(aw_prot_i))
    else $error("AW changed while stalled");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_valid_i && !w_ready_o |=> w_valid_i && $stable(w_data_i) && $stable(w_strb_i))
    else $error("W changed while stalled");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_valid_i && !ar_ready_o |=> ar_valid_i && $stable(ar_addr_i))
    else $error("AR changed while stalled");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
    else $error("B changed while stalled");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
    else $error("R changed while stalled");

  // AW and W are accepted together and only while both are valid
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_ready_o || w_ready_o |-> aw_ready_o && w_ready_o && aw_valid_i && w_valid_i)
    else $error("AW and W ready without both valids");

endmodule

bind axi_lite_mem_top axi_lite_mem_sva i_sva (
  .clk_i     (clk_i),      .rst_n_i   (rst_n_i),
  .aw_addr_i (aw_addr_i),  .aw_prot_i (aw_prot_i),
  .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o),
  .w_data_i  (w_data_i),   .w_strb_i  (w_strb_i),
  .w_valid_i (w_valid_i),  .w_ready_o (w_ready_o),
  .b_resp_o  (b_resp_o),   .b_valid_o (b_valid_o),
  .b_ready_i (b_ready_i),
  .ar_addr_i (ar_addr_i),  .ar_valid_i(ar_valid_i),
  .ar_ready_o(ar_ready_o),
  .r_data_o  (r_data_o),   .r_resp_o  (r_resp_o),
  .r_valid_o (r_valid_o),  .r_ready_i (r_ready_i)
);

//--- verification/tb_axi_lite_mem.sv
`timescale 1ns/1ps

module tb_axi_lite_mem;
  import axi_lite_mem_pkg::*;

  localparam int unsigned ClkPeriod = 8;
  localparam int unsigned NumTests  = 5;
  localparam int unsigned MaxWait   = 20;
  localparam logic [31:0] LfsrSeed  = 32'h0ed6_0420;
  localparam logic [AddrWidth-1:0] MemBytes = AddrWidth'(MemWords * StrbWidth);

  logic                  clk_i;
  logic                  rst_n_i;
  logic [AddrWidth-1:0]  aw_addr_i;
  logic [ProtWidth-1:0]  aw_prot_i;
  logic                  aw_valid_i;
  logic                  aw_ready_o;
  logic [DataWidth-1:0]  w_data_i;
  logic [StrbWidth-1:0]  w_strb_i;
  logic                  w_valid_i;
  logic                  w_ready_o;
  resp_e                 b_resp_o;
  logic                  b_valid_o;
  logic                  b_ready_i;
  logic [AddrWidth-1:0]  ar_addr_i;
  logic [ProtWidth-1:0]  ar_prot_i;
  logic                  ar_valid_i;
  logic                  ar_ready_o;
  logic [DataWidth-1:0]  r_data_o;
  resp_e                 r_resp_o;
  logic                  r_valid_o;
  logic                  r_ready_i;
  logic [CacheWidth-1:0] aw_cache_i;
  logic [CacheWidth-1:0] ar_cache_i;

  logic [31:0]          lfsr_q;
  logic [DataWidth-1:0] shadow [MemWords];
  int unsigned          errors;

  axi_lite_mem_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(NumTests * 40 * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the tests did not finish", NumTests * 40);
    $display("Test failures found");
    $fatal(1, "Simulation timed out");
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_bits(input int unsigned n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  // Range first, then privilege on the upper half
  function automatic resp_e expected_wr_resp(input logic [AddrWidth-1:0] addr,
                                             input logic [2:0]           prot);
    resp_e resp;
    resp = RESP_OKAY;
    if (addr >= MemBytes) begin
      resp = RESP_DECERR;
    end else if (addr >= PrivBase && !prot[0]) begin
      resp = RESP_SLVERR;
    end
    return resp;
  endfunction

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Latency counts rising edges from the handshake to the first b_valid
  task automatic axi_write(input logic [AddrWidth-1:0] addr, input logic [2:0] prot,
                           input logic [3:0] cache, input logic [31:0] data,
                           input logic [3:0] strb, input int unsigned hold,
                           output resp_e resp, output int unsigned lat);
    int unsigned waited;
    @(negedge clk_i);
    aw_addr_i  = addr;
    aw_prot_i  = prot;
    aw_cache_i = cache;
    w_data_i   = data;
    w_strb_i   = strb;
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    b_ready_i  = (hold == 0);
    waited     = 0;
    #1;
    while (!(aw_ready_o && w_ready_o)) begin
      waited++;
      if (waited > MaxWait) begin
        report_failure("The write address and data were never accepted");
      end
      @(negedge clk_i);
      #1;
    end
    // Handshake on the coming rising edge
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    lat        = 1;
    #1;
    while (!b_valid_o) begin
      lat++;
      if (lat > MaxWait) begin
        report_failure("The write response never arrived");
      end
      @(negedge clk_i);
      #1;
    end
    resp = b_resp_o;
    for (int unsigned i = 0; i < hold; i++) begin
      @(negedge clk_i);
      #1;
      check_value("b_valid_o", 32'(b_valid_o), 32'd1);
      check_value("b_resp_o", 32'(b_resp_o), 32'(resp));
    end
    if (hold > 0) begin
      @(negedge clk_i);
      b_ready_i = 1'b1;
    end
    @(posedge clk_i);
  endtask

  task automatic axi_read(input logic [AddrWidth-1:0] addr, input int unsigned hold,
                          output logic [31:0] data, output resp_e resp,
                          output int unsigned lat);
    int unsigned waited;
    @(negedge clk_i);
    ar_addr_i  = addr;
    ar_prot_i  = 3'b000;
    ar_valid_i = 1'b1;
    r_ready_i  = (hold == 0);
    waited     = 0;
    #1;
    while (!ar_ready_o) begin
      waited++;
      if (waited > MaxWait) begin
        report_failure("The read address was never accepted");
      end
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    lat        = 1;
    #1;
    while (!r_valid_o) begin
      lat++;
      if (lat > MaxWait) begin
        report_failure("The read response never arrived");
      end
      @(negedge clk_i);
      #1;
    end
    data = r_data_o;
    resp = r_resp_o;
    for (int unsigned i = 0; i < hold; i++) begin
      @(negedge clk_i);
      // Second read to the same word must wait behind the stalled response
      ar_valid_i = 1'b1;
      #1;
      check_value("ar_ready_o", 32'(ar_ready_o), 32'd0);
      check_value("r_valid_o", 32'(r_valid_o), 32'd1);
      check_value("r_data_o", r_data_o, data);
      check_value("r_resp_o", 32'(r_resp_o), 32'(resp));
    end
    if (hold > 0) begin
      @(negedge clk_i);
      r_ready_i = 1'b1;
    end
    @(posedge clk_i);
  endtask

  task automatic write_and_check(input logic [AddrWidth-1:0] addr, input logic [2:0] prot,
                                 input logic [3:0] cache, input logic [31:0] data,
                                 input logic [3:0] strb, input int unsigned hold);
    resp_e       resp;
    resp_e       exp_resp;
    int unsigned lat;
    int unsigned exp_lat;
    exp_resp = expected_wr_resp(addr, prot);
    // Rejected writes answer with the early timing
    exp_lat  = (cache[CacheBufferableBit] || exp_resp != RESP_OKAY) ? 1 : 2;
    axi_write(addr, prot, cache, data, strb, hold, resp, lat);
    check_value("b_resp_o", 32'(resp), 32'(exp_resp));
    check_value("b_valid_o latency", lat, exp_lat);
    if (exp_resp == RESP_OKAY) begin
      shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], data, strb);
    end
  endtask

  task automatic read_and_check(input logic [AddrWidth-1:0] addr, input int unsigned hold);
    logic [31:0] data;
    logic [31:0] exp_data;
    resp_e       resp;
    resp_e       exp_resp;
    int unsigned lat;
    exp_resp = (addr >= MemBytes) ? RESP_DECERR : RESP_OKAY;
    exp_data = (addr >= MemBytes) ? '0 : shadow[addr[9:2]];
    axi_read(addr, hold, data, resp, lat);
    check_value("r_resp_o", 32'(resp), 32'(exp_resp));
    check_value("r_data_o", data, exp_data);
    check_value("r_valid_o latency", lat, 32'd2);
  endtask

  task automatic test_buffered_writes();
    logic [31:0]          rnd;
    logic [AddrWidth-1:0] addr;
    for (int i = 0; i < 8; i++) begin
      rnd  = lfsr_bits(7);
      addr = AddrWidth'({rnd[6:0], 2'b00});
      write_and_check(addr, 3'b000, 4'b0011, lfsr_bits(32), 4'hf, 0);
      rnd  = lfsr_bits(4);
      write_and_check(addr, 3'b000, 4'b0011, lfsr_bits(32), rnd[3:0], 0);
      read_and_check(addr, 0);
    end
  endtask

  task automatic test_non_buffered_write();
    write_and_check(12'h1f0, 3'b000, 4'b0010, lfsr_bits(32), 4'hf, 0);
    read_and_check(12'h1f0, 0);
  endtask

  task automatic test_privilege();
    write_and_check(12'h2a4, 3'b001, 4'b0011, lfsr_bits(32), 4'hf, 0);
    // Unprivileged write is refused and leaves the word alone
    write_and_check(12'h2a4, 3'b000, 4'b0010, lfsr_bits(32), 4'hf, 0);
    read_and_check(12'h2a4, 0);
    write_and_check(12'h2a4, 3'b001, 4'b0011, lfsr_bits(32), 4'hf, 0);
    read_and_check(12'h2a4, 0);
  endtask

  task automatic test_decode();
    write_and_check(12'h400, 3'b001, 4'b0010, lfsr_bits(32), 4'hf, 0);
    read_and_check(12'h400, 0);
    read_and_check(12'hffc, 0);
  endtask

  task automatic test_back_pressure();
    write_and_check(12'h080, 3'b000, 4'b0011, lfsr_bits(32), 4'hf, 4);
    read_and_check(12'h080, 4);
    // The queued read goes through once R has completed
    read_and_check(12'h080, 0);
  endtask

  initial begin
    lfsr_q     = LfsrSeed;
    errors     = 0;
    rst_n_i    = 1'b0;
    aw_addr_i  = '0;
    aw_prot_i  = '0;
    aw_valid_i = 1'b0;
    aw_cache_i = 4'b0011;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_valid_i  = 1'b0;
    b_ready_i  = 1'b1;
    ar_addr_i  = '0;
    ar_prot_i  = '0;
    ar_valid_i = 1'b0;
    ar_cache_i = 4'b0010;
    r_ready_i  = 1'b1;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    test_buffered_writes();
    test_non_buffered_write();
    test_privilege();
    test_decode();
    test_back_pressure();
    repeat (2) @(negedge clk_i);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- src.f
hw/axi_lite_mem_pkg.sv
hw/sram_sp.sv
hw/axi_lite_to_axi.sv
hw/axi_mem_sub.sv
hw/axi_lite_mem_top.sv
verification/axi_lite_mem_sva.sv
verification/tb_axi_lite_mem.sv

//--- Makefile
TOP  := tb_axi_lite_mem
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --assert --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
